// File: sources.f
+incdir+include
verilog/shifterPkg.sv
verilog/shiftDecoder.sv
verilog/barrelRotator.sv
verilog/shiftMask.sv
verilog/shiftControl.sv
verilog/operand2Shifter.sv
dv/operand2ShifterTb.sv

// File: Bender.yml
package:
  name: operand2_shifter

sources:
  - files:
      - verilog/shifterPkg.sv
      - verilog/shiftDecoder.sv
      - verilog/barrelRotator.sv
      - verilog/shiftMask.sv
      - verilog/shiftControl.sv
      - verilog/operand2Shifter.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/operand2ShifterTb.sv

// File: include/shiftModel.svh
`ifndef SHIFT_MODEL_SVH
`define SHIFT_MODEL_SVH

// Expected {carry, result} for one operand under the ARM shift rules
function automatic logic [shifterPkg::dataWidth:0] shiftModel(
  input logic [shifterPkg::dataWidth-1:0]     a,
  input shifterPkg::shiftTypeE                shType,
  input logic [shifterPkg::shamtWidth-1:0]    rShamt,
  input logic [shifterPkg::rsrShamtWidth-1:0] rsrShamt,
  input logic                                 isRtype,
  input logic                                 isRsrType,
  input logic                                 zeroRotate,
  input logic                                 prevCflag
);
  logic [2*shifterPkg::dataWidth-1:0]        wide;
  logic signed [2*shifterPkg::dataWidth-1:0] sWide;
  logic [shifterPkg::dataWidth-1:0]          res;
  logic                                      carry;
  int unsigned                               amt;
  int unsigned                               rot;

  // Not a shift, immediate arrives already rotated
  if (!isRtype && !isRsrType) begin
    return {zeroRotate ? prevCflag : a[shifterPkg::dataWidth-1], a};
  end

  amt = isRsrType ? rsrShamt : rShamt;

  if (amt == 0) begin
    if (isRsrType || shType == shifterPkg::shLsl) begin
      return {prevCflag, a}; // Unchanged, C kept
    end
    if (shType == shifterPkg::shRor) begin
      return {a[0], prevCflag, a[shifterPkg::dataWidth-1:1]}; // RRX
    end
    amt = shifterPkg::dataWidth; // LSR/ASR #0 mean 32
  end

  case (shType)
    shifterPkg::shLsl: begin
      wide  = {{shifterPkg::dataWidth{1'b0}}, a} << amt;
      res   = wide[shifterPkg::dataWidth-1:0];
      carry = wide[shifterPkg::dataWidth]; // Last bit out the top
    end
    shifterPkg::shLsr: begin
      wide  = {a, {shifterPkg::dataWidth{1'b0}}} >> amt;
      res   = wide[2*shifterPkg::dataWidth-1:shifterPkg::dataWidth];
      carry = wide[shifterPkg::dataWidth-1];
    end
    shifterPkg::shAsr: begin
      sWide = $signed({a, {shifterPkg::dataWidth{1'b0}}}) >>> amt;
      res   = sWide[2*shifterPkg::dataWidth-1:shifterPkg::dataWidth];
      carry = sWide[shifterPkg::dataWidth-1];
    end
    default: begin
      rot = amt % shifterPkg::dataWidth;
      if (rot == 0) begin
        res = a; // Multiple of 32
      end else begin
        res = (a >> rot) | (a << (shifterPkg::dataWidth - rot));
      end
      carry = res[shifterPkg::dataWidth-1];
    end
  endcase

  return {carry, res};
endfunction

`endif

// File: dv/operand2ShifterTb.sv
`timescale 1ns/10ps

module operand2ShifterTb;

  import shifterPkg::*;

  `include "shiftModel.svh"

  localparam int clkPeriod    = 8;
  localparam int resetCycles  = 8;
  localparam int numImm       = 4 * 32;  // Every kind, every immediate amount
  localparam int numReg       = 4 * 12 * 2;
  localparam int numPlain     = 16;
  localparam int numStream    = 400;
  localparam int totalOps     = 1 + numImm + numReg + numPlain + numStream;
  localparam int watchdogNs   = (totalOps + resetCycles) * clkPeriod + 4000;

  logic                     clk;
  logic                     arstN;
  logic                     inValid;
  logic [dataWidth-1:0]     a;
  shiftTypeE                shType;
  logic [shamtWidth-1:0]    rShamt;
  logic [rsrShamtWidth-1:0] rsrShamt;
  logic                     isRtype;
  logic                     isRsrType;
  logic                     zeroRotate;
  logic                     prevCflag;
  logic                     multCsel;
  logic                     multCarryIn;
  logic                     outValid;
  logic [dataWidth-1:0]     result;
  logic                     carryOut;

  logic [dataWidth:0] expQ[$]; // {carry, result} in issue order
  int sentCount  = 0;
  int recvCount  = 0;
  int errorCount = 0;

  operand2Shifter operand2Shifter_inst (
    .clk         (clk),
    .arstN       (arstN),
    .inValid     (inValid),
    .a           (a),
    .shType      (shType),
    .rShamt      (rShamt),
    .rsrShamt    (rsrShamt),
    .isRtype     (isRtype),
    .isRsrType   (isRsrType),
    .zeroRotate  (zeroRotate),
    .prevCflag   (prevCflag),
    .multCsel    (multCsel),
    .multCarryIn (multCarryIn),
    .outValid    (outValid),
    .result      (result),
    .carryOut    (carryOut)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic logMismatch(input string name, input logic [dataWidth-1:0] expV,
                             input logic [dataWidth-1:0] gotV);
    $display("[ERROR] %0t ns %s expected 0x%08h got 0x%08h", $time, name, expV, gotV);
    errorCount++;
  endtask

  task automatic reportTest(input string name, input int errBefore, input int ops);
    $display("Test %-24s %4d operands, %0d errors", name, ops, errorCount - errBefore);
  endtask

  // One operand per rising edge, expectation queued at the same time
  task automatic applyOp(
    input logic [dataWidth-1:0]     opA,
    input shiftTypeE                kind,
    input logic [shamtWidth-1:0]    immAmt,
    input logic [rsrShamtWidth-1:0] regAmt,
    input logic                     immForm,
    input logic                     regForm,
    input logic                     zRot,
    input logic                     cIn,
    input logic                     mSel,
    input logic                     mCarry
  );
    @(posedge clk);
    inValid     <= 1'b1;
    a           <= opA;
    shType      <= kind;
    rShamt      <= immAmt;
    rsrShamt    <= regAmt;
    isRtype     <= immForm;
    isRsrType   <= regForm;
    zeroRotate  <= zRot;
    prevCflag   <= cIn;
    multCsel    <= mSel;
    multCarryIn <= mCarry;
    expQ.push_back(shiftModel(opA, kind, immAmt, regAmt, immForm, regForm, zRot, cIn));
    sentCount++;
  endtask

  // Drop the strobe and let the queue empty
  task automatic drain();
    @(posedge clk);
    inValid <= 1'b0;
    while (expQ.size() != 0) @(negedge clk);
  endtask

  // Compare on the falling edge, away from the register update
  always @(negedge clk) begin
    logic [dataWidth:0] expV;
    if (arstN && outValid) begin
      recvCount++; // Every valid output, expected or not
      if (expQ.size() == 0) begin
        $display("Output arrived at %0t ns with no operand outstanding", $time);
        errorCount++;
      end else begin
        expV = expQ.pop_front();
        assert (result === expV[dataWidth-1:0]) else begin
          logMismatch("result", expV[dataWidth-1:0], result);
        end
        assert (carryOut === expV[dataWidth]) else begin
          logMismatch("carryOut", 32'(expV[dataWidth]), 32'(carryOut));
        end
      end
    end
  end

  task automatic testReset();
    int errBefore;
    errBefore = errorCount;
    @(negedge clk);  // No rising edge since release yet
    assert (outValid === 1'b0) else logMismatch("outValid", 32'd0, 32'(outValid));
    assert (result === '0) else logMismatch("result", 32'd0, result);
    assert (carryOut === 1'b0) else logMismatch("carryOut", 32'd0, 32'(carryOut));
    applyOp(32'h8000_0001, shLsl, 5'd1, 8'd0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    @(posedge clk);
    inValid <= 1'b0;
    @(negedge clk);  // One cycle after the strobe
    assert (outValid === 1'b1) else logMismatch("outValid", 32'd1, 32'(outValid));
    @(negedge clk);
    assert (outValid === 1'b0) else logMismatch("outValid", 32'd0, 32'(outValid));
    reportTest("reset and latency", errBefore, 1);
  endtask

  task automatic testImmediate();
    int errBefore;
    errBefore = errorCount;
    for (int k = 0; k < 4; k++) begin
      for (int n = 0; n < 32; n++) begin
        // Includes LSR/ASR #0 as 32 and ROR #0 as RRX
        applyOp($urandom, shiftTypeE'(k), 5'(n), 8'($urandom), 1'b1, 1'b0,
                1'($urandom), 1'($urandom), 1'b0, 1'b0);
      end
    end
    drain();
    reportTest("immediate amounts", errBefore, numImm);
  endtask

  task automatic testRegister();
    int unsigned regAmts[12] = '{0, 1, 2, 15, 31, 32, 33, 63, 64, 128, 200, 255};
    int errBefore;
    logic [dataWidth-1:0] opA;
    errBefore = errorCount;
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 12; i++) begin
        for (int s = 0; s < 2; s++) begin
          opA = $urandom;
          opA[dataWidth-1] = s[0]; // Both signs for ASR fill
          applyOp(opA, shiftTypeE'(k), 5'($urandom), 8'(regAmts[i]), 1'b0, 1'b1,
                  1'($urandom), 1'($urandom), 1'b0, 1'b0);
        end
      end
    end
    drain();
    reportTest("register amounts", errBefore, numReg);
  endtask

  task automatic testPlain();
    int errBefore;
    errBefore = errorCount;
    for (int i = 0; i < numPlain; i++) begin
      applyOp($urandom, shiftTypeE'($urandom_range(0, 3)), 5'($urandom), 8'($urandom),
              1'b0, 1'b0, i[0], i[1], 1'b0, 1'b0); // Carry rule on zeroRotate
    end
    drain();
    reportTest("rotated immediates", errBefore, numPlain);
  endtask

  task automatic testStream();
    int errBefore;
    int sentBefore;
    int recvBefore;
    int form;
    errBefore  = errorCount;
    sentBefore = sentCount;
    recvBefore = recvCount;
    for (int i = 0; i < numStream; i++) begin
      form = $urandom_range(0, 2); // None, immediate or register amount
      applyOp($urandom, shiftTypeE'($urandom_range(0, 3)), 5'($urandom), 8'($urandom),
              form == 1, form == 2, 1'($urandom), 1'($urandom),
              1'($urandom), 1'($urandom));
    end
    drain();
    assert ((recvCount - recvBefore) == (sentCount - sentBefore)) else begin
      $display("Stream lost outputs: sent %0d, received %0d",
               sentCount - sentBefore, recvCount - recvBefore);
      errorCount++;
    end
    reportTest("back-to-back stream", errBefore, numStream);
  endtask

  initial begin
    void'($urandom(32'hdc2b_3d1a));
    arstN       = 1'b0;
    inValid     = 1'b0;
    a           = '1; // Unlike the reset value of result
    shType      = shLsl;
    rShamt      = '0;
    rsrShamt    = '0;
    isRtype     = 1'b0;
    isRsrType   = 1'b0;
    zeroRotate  = 1'b0;
    prevCflag   = 1'b0;
    multCsel    = 1'b0;
    multCarryIn = 1'b0;
    repeat (resetCycles) @(posedge clk);
    arstN <= 1'b1;
    testReset();
    testImmediate();
    testRegister();
    testPlain();
    testStream();
    $display("Totals: sent %0d, received %0d, errors %0d", sentCount, recvCount, errorCount);
    if (errorCount == 0 && recvCount == sentCount) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Bound on the whole run from the operand count
  initial begin
    #(watchdogNs);
    $display("Timeout after %0d ns, outputs stopped arriving: sent %0d, received %0d",
             watchdogNs, sentCount, recvCount);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: verilog/operand2Shifter.sv
`timescale 1ns/10ps

module operand2Shifter (
  input  logic                                 clk,
  input  logic                                 arstN,
  input  logic                                 inValid,
  input  logic [shifterPkg::dataWidth-1:0]     a,
  input  shifterPkg::shiftTypeE                shType,
  input  logic [shifterPkg::shamtWidth-1:0]    rShamt,
  input  logic [shifterPkg::rsrShamtWidth-1:0] rsrShamt,
  input  logic                                 isRtype,    // Immediate amount shift
  input  logic                                 isRsrType,  // Register amount shift
  input  logic                                 zeroRotate, // Immediate rotated by 0
  input  logic                                 prevCflag,
  input  logic                                 multCsel,
  input  logic                                 multCarryIn,
  output logic                                 outValid,
  output logic [shifterPkg::dataWidth-1:0]     result,
  output logic                                 carryOut
);

  import shifterPkg::*;

  logic [shamtWidth-1:0] shamt;
  logic [shamtWidth-1:0] shctl5;
  logic [7:0]            shctl8;
  logic                  shift;
  logic                  left;
  logic                  arith;
  logic                  longShift;
  logic                  isRrx;
  logic                  rrxIn;
  logic                  shifterCarryOut;
  logic [dataWidth-1:0]  rotated;
  logic [dataWidth-1:0]  maskedResult;

  shiftControl shiftControl_inst (
    .shType          (shType),
    .rShamt0         (rShamt),
    .rsrShamt        (rsrShamt),
    .isRtype         (isRtype),
    .isRsrType       (isRsrType),
    .zeroRotate      (zeroRotate),
    .prevCflag       (prevCflag),
    .multCsel        (multCsel),
    .multCarryIn     (multCarryIn),
    .a0              (a[0]),
    .a31             (a[dataWidth-1]),
    .rot0            (rotated[0]),           // a[32-n] for LSL
    .rot31           (rotated[dataWidth-1]), // a[n-1] for right shifts
    .shamt           (shamt),
    .shctl5          (shctl5),
    .shctl8          (shctl8),
    .shift           (shift),
    .left            (left),
    .arith           (arith),
    .longShift       (longShift),
    .isRrx           (isRrx),
    .rrxIn           (rrxIn),
    .shifterCarryOut (shifterCarryOut)
  );

  barrelRotator barrelRotator_inst (
    .a       (a),
    .shctl5  (shctl5),
    .shctl8  (shctl8),
    .rotated (rotated)
  );

  shiftMask shiftMask_inst (
    .rotated      (rotated),
    .a31          (a[dataWidth-1]),
    .shamt        (shamt),
    .longShift    (longShift),
    .shift        (shift),
    .left         (left),
    .arith        (arith),
    .isRrx        (isRrx),
    .rrxIn        (rrxIn),
    .maskedResult (maskedResult)
  );

  // Single output stage, valid follows the strobe by one cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
      result   <= '0;
      carryOut <= 1'b0;
    end else begin
      outValid <= inValid;
      result   <= maskedResult;
      carryOut <= shifterCarryOut;
    end
  end

endmodule

// File: verilog/shiftControl.sv
`timescale 1ns/10ps

module shiftControl (
  input  shifterPkg::shiftTypeE                  shType,
  input  logic [shifterPkg::shamtWidth-1:0]      rShamt0,  // Immediate amount field
  input  logic [shifterPkg::rsrShamtWidth-1:0]   rsrShamt, // Rs[7:0]
  input  logic                                   isRtype,
  input  logic                                   isRsrType,
  input  logic                                   zeroRotate,
  input  logic                                   prevCflag,
  input  logic                                   multCsel,
  input  logic                                   multCarryIn,
  input  logic                                   a0,
  input  logic                                   a31,
  input  logic                                   rot0,
  input  logic                                   rot31,
  output logic [shifterPkg::shamtWidth-1:0]      shamt,
  output logic [shifterPkg::shamtWidth-1:0]      shctl5,
  output logic [7:0]                             shctl8,
  output logic                                   shift,
  output logic                                   left,
  output logic                                   arith,
  output logic                                   longShift,
  output logic                                   isRrx,
  output logic                                   rrxIn,
  output logic                                   shifterCarryOut
);

  import shifterPkg::*;

  logic                  shiftSelect; // Operand goes through the shifter at all
  logic                  immZero;     // Immediate form with #0
  logic                  rrx;
  logic [shamtWidth:0]   effAmt;      // Effective amount, bit 5 means 32 or more
  logic                  shiftZero;
  logic                  shift32;
  logic                  shiftOver;   // 33 to 255, register form only

  assign shiftSelect = isRtype | isRsrType;
  assign immZero     = isRtype & ~isRsrType & (rShamt0 == '0);
  assign rrx         = immZero & (shType == shRor); // ROR #0 encodes RRX
  assign isRrx       = rrx;

  // Amount seen by rotator and mask
  always_comb begin
    if (!shiftSelect) begin
      effAmt = '0; // Immediate operand passes untouched
    end else if (isRsrType) begin
      effAmt = {|rsrShamt[rsrShamtWidth-1:shamtWidth], rsrShamt[shamtWidth-1:0]};
    end else if (rrx) begin
      effAmt = (shamtWidth+1)'(1); // RRX moves like LSR #1
    end else begin
      // LSR/ASR #0 mean 32, LSL #0 stays 0
      effAmt = {(rShamt0 == '0) && (shType != shLsl), rShamt0};
    end
  end

  assign longShift = effAmt[shamtWidth];
  assign shamt     = effAmt[shamtWidth-1:0];

  // Operation kind for the mask stage
  always_comb begin
    case (shType)
      shLsl:   {shift, left, arith} = 3'b110;
      shLsr:   {shift, left, arith} = 3'b100;
      shAsr:   {shift, left, arith} = 3'b101;
      default: {shift, left, arith} = rrx ? 3'b100 : 3'b001; // RRX looks like LSR
    endcase
  end

  // Fill bit, C flag for RRX else multiply carry or bit 0
  assign rrxIn = rrx ? prevCflag : (multCsel ? multCarryIn : a0);

  shiftDecoder shiftDecoder_inst (
    .shamt  (shamt),
    .left   (left),
    .shctl5 (shctl5),
    .shctl8 (shctl8)
  );

  // Amount classes for the carry table
  assign shiftZero = isRsrType ? (rsrShamt == '0) : (immZero & (shType == shLsl));
  assign shift32   = isRsrType ? (rsrShamt == rsrShamtWidth'(dataWidth))
                               : (immZero & (shType != shLsl)); // Includes RRX
  assign shiftOver = isRsrType & (rsrShamt > rsrShamtWidth'(dataWidth));

  always_comb begin
    shifterCarryOut = prevCflag;
    if (!shiftSelect) begin
      shifterCarryOut = zeroRotate ? prevCflag : a31; // Rotated immediate
    end else if (shiftZero) begin
      shifterCarryOut = prevCflag; // Any kind by 0 keeps C
    end else if (shift32) begin
      case (shType)
        shLsl:   shifterCarryOut = a0;                      // Register form only
        shLsr:   shifterCarryOut = a31;
        shAsr:   shifterCarryOut = a31;
        default: shifterCarryOut = isRsrType ? a31 : a0;    // RRX takes old bit 0
      endcase
    end else if (shiftOver) begin
      case (shType)
        shLsl:   shifterCarryOut = 1'b0;
        shLsr:   shifterCarryOut = 1'b0;
        shAsr:   shifterCarryOut = a31;
        default: shifterCarryOut = rot31; // ROR wraps modulo 32
      endcase
    end else begin
      // 1 to 31, last bit out on either side
      shifterCarryOut = (shType == shLsl) ? rot0 : rot31;
    end
  end

endmodule

// File: verilog/shiftMask.sv
`timescale 1ns/10ps

module shiftMask (
  input  logic [shifterPkg::dataWidth-1:0]  rotated,
  input  logic                              a31,
  input  logic [shifterPkg::shamtWidth-1:0] shamt,
  input  logic                              longShift,
  input  logic                              shift,     // Low for ROR
  input  logic                              left,
  input  logic                              arith,
  input  logic                              isRrx,
  input  logic                              rrxIn,
  output logic [shifterPkg::dataWidth-1:0]  maskedResult
);

  import shifterPkg::*;

  logic [dataWidth-1:0] keep;   // Ones where rotated bits survive
  logic [dataWidth-1:0] fill;   // Value for cleared positions
  logic [dataWidth-1:0] shaped;

  // Left keeps the high 32 - n bits, right keeps the low 32 - n
  assign keep = left ? ({dataWidth{1'b1}} << shamt) : ({dataWidth{1'b1}} >> shamt);

  assign fill = arith ? {dataWidth{a31}} : '0; // Sign fill for ASR

  assign shaped = (rotated & keep) | (fill & ~keep);

  always_comb begin
    if (!shift) begin
      maskedResult = rotated; // Plain rotation
    end else if (longShift) begin
      maskedResult = fill;    // Everything shifted out
    end else if (isRrx) begin
      // LSR #1 shape with the carry on top
      maskedResult = {rrxIn, shaped[dataWidth-2:0]};
    end else begin
      maskedResult = shaped;
    end
  end

endmodule

// File: verilog/barrelRotator.sv
`timescale 1ns/10ps

module barrelRotator (
  input  logic [shifterPkg::dataWidth-1:0]  a,
  input  logic [shifterPkg::shamtWidth-1:0] shctl5,
  input  logic [7:0]                        shctl8,
  output logic [shifterPkg::dataWidth-1:0]  rotated
);

  import shifterPkg::*;

  logic [dataWidth-1:0] coarse; // After the byte stage

  // Right rotate by a small constant
  function automatic logic [dataWidth-1:0] rotR(input logic [dataWidth-1:0] v,
                                                input int unsigned n);
    logic [2*dataWidth-1:0] dbl;
    dbl = {v, v} >> n;
    return dbl[dataWidth-1:0];
  endfunction

  // Coarse stage by whole bytes
  always_comb begin
    case (shctl5[4:3])
      2'd0:    coarse = a;
      2'd1:    coarse = {a[7:0], a[31:8]};   // 8
      2'd2:    coarse = {a[15:0], a[31:16]}; // 16
      default: coarse = {a[23:0], a[31:24]}; // 24
    endcase
  end

  // Fine stage, AND-OR over the one-hot select
  always_comb begin
    rotated = '0;
    for (int i = 0; i < 8; i++) begin
      if (shctl8[i]) begin
        rotated |= rotR(coarse, i);
      end
    end
  end

endmodule

// File: verilog/shiftDecoder.sv
`timescale 1ns/10ps

module shiftDecoder (
  input  logic [shifterPkg::shamtWidth-1:0] shamt,
  input  logic                              left,
  output logic [shifterPkg::shamtWidth-1:0] shctl5, // Right rotate amount
  output logic [7:0]                        shctl8  // One-hot fine select
);

  import shifterPkg::*;

  logic [shamtWidth-1:0] rotAmt;

  // Left by n equals right rotate by 32 - n, two's complement does the modulo
  assign rotAmt = left ? (~shamt + 1'b1) : shamt;

  assign shctl5 = rotAmt;

  // Fine stage wants one line per residue 0 to 7
  always_comb begin
    shctl8 = '0;
    for (int i = 0; i < 8; i++) begin
      if (rotAmt[2:0] == 3'(i)) begin
        shctl8[i] = 1'b1;
      end
    end
  end

endmodule

// File: verilog/shifterPkg.sv
package shifterPkg;

  // Operand width of the datapath
  localparam int dataWidth = 32;

  // Rotator amount width, enough for 0 to 31
  localparam int shamtWidth = 5;

  // Amount taken from the bottom byte of Rs
  localparam int rsrShamtWidth = 8;

  // Shift kind as encoded in instruction bits [6:5]
  typedef enum logic [1:0] {
    shLsl = 2'b00, // Logical left
    shLsr = 2'b01, // Logical right
    shAsr = 2'b10, // Arithmetic right
    shRor = 2'b11  // Rotate right, RRX when immediate #0
  } shiftTypeE;

endpackage
